/* compile.f */
verilog/bufferCfgPkg.sv
verilog/bufferTypesPkg.sv
verilog/laneFifo.sv
verilog/laneDispatcher.sv
verilog/roundRobinDrain.sv
verilog/laneBuffer.sv
dv/laneBuffer_assert.sv
dv/laneBufferTb.sv

/* dv/laneBufferTb.sv */
`timescale 1ns/10ps
`default_nettype none

module laneBufferTb;

  logic CLK = 1'b0;
  logic RESETN;
  bufferTypesPkg::laneWordT inWord;
  logic inValid;
  logic downCredit = 1'b0;
  bufferTypesPkg::laneMaskT upCredit;
  logic creditError;
  bufferTypesPkg::laneWordT outWord;
  logic outValid;

  // E lines go straight into the per-lane queues
  byte cmdList[$];
  int laneList[$];
  int dataList[$];
  int expQ[bufferCfgPkg::NUM_LANES][$];
  int lineCount = 0;

  // Upstream side bookkeeping
  int upCredits[bufferCfgPkg::NUM_LANES];
  int accepted[bufferCfgPkg::NUM_LANES];
  int upPulses[bufferCfgPkg::NUM_LANES];
  int inFlight[bufferCfgPkg::NUM_LANES];
  int acceptedTotal = 0;
  logic sawNoCreditWord = 1'b0;

  // Downstream side bookkeeping
  int outCount = 0;
  int returnedCount = 0;
  int heldCount = 0;
  int returnTimes[$];
  int cycleCount = 0;
  logic creditsHeld = 1'b0;
  logic fairWindow = 1'b0;
  int fairChecks = 0;
  int prevLane = -1;
  logic [7:0] lfsrState = 8'd52;

  laneBuffer u_laneBuffer (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .inWord      (inWord),
    .inValid     (inValid),
    .upCredit    (upCredit),
    .creditError (creditError),
    .outWord     (outWord),
    .outValid    (outValid),
    .downCredit  (downCredit)
  );

  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
  end

  task automatic stopOnError(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      stopOnError($sformatf("CHECK FAILED %s: actual 0x%0h expected 0x%0h",
                            name, actual, expected));
    end
  endtask

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsrStep(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // Two LFSR bits give 0 to 3 cycles
  function automatic int randomDelay();
    int delay;
    delay = 0;
    for (int b = 0; b < 2; b++) begin
      lfsrState = lfsrStep(lfsrState);
      delay = (delay << 1) | int'(lfsrState[0]);
    end
    return delay;
  endfunction

  task automatic loadGolden();
    int fd;
    int code;
    int lane;
    int data;
    logic [7:0] cmd;
    logic [8*160-1:0] restOfLine;
    fd = $fopen("dv/laneBuffer_golden.txt", "r");
    if (fd == 0) begin
      stopOnError("could not open dv/laneBuffer_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", cmd);
        if (code != 1) begin
          continue;
        end
        if (cmd == "#") begin
          code = $fgets(restOfLine, fd);
        end else if (cmd == "I" || cmd == "E" || cmd == "X") begin
          code = $fscanf(fd, "%h %h", lane, data);
          if (code != 2 || lane >= bufferCfgPkg::NUM_LANES) begin
            stopOnError($sformatf("bad golden line %0d", lineCount + 1));
          end
          lineCount++;
          if (cmd == "E") begin
            expQ[lane].push_back(data);
          end else begin
            cmdList.push_back(cmd);
            laneList.push_back(lane);
            dataList.push_back(data);
          end
        end else begin
          lineCount++;
          cmdList.push_back(cmd);
          laneList.push_back(0);
          dataList.push_back(0);
        end
      end
      $fclose(fd);
    end
  endtask

  // Called and returns 2 ns after a rising edge
  task automatic sendWord(input int lane, input int data, input logic noCredit);
    if (noCredit) begin
      if (upCredits[lane] != 0) begin
        stopOnError($sformatf("X word for lane %0d while %0d credits remain",
                              lane, upCredits[lane]));
      end
      checkValue("creditError", creditError, 1'b0);
    end else begin
      while (upCredits[lane] == 0) begin
        @(posedge CLK);
        #2;
      end
    end
    inWord.lane = bufferTypesPkg::laneIdT'(lane);
    inWord.data = bufferTypesPkg::dataT'(data);
    inValid = 1'b1;
    if (noCredit) begin
      sawNoCreditWord = 1'b1;
    end else begin
      upCredits[lane]--;
      accepted[lane]++;
      inFlight[lane]++;
      acceptedTotal++;
    end
    @(posedge CLK);
    #2;
    inValid = 1'b0;
    if (noCredit) begin
      @(negedge CLK);
      checkValue("creditError", creditError, 1'b1);
      @(posedge CLK);
      #2;
    end
  endtask

  task automatic releaseCredits();
    // Give the last words time to land in their FIFOs
    repeat (3) begin
      @(posedge CLK);
      #2;
    end
    creditsHeld = 1'b0;
    fairWindow = 1'b1;
    while (heldCount > 0) begin
      returnTimes.push_back(cycleCount + 1 + randomDelay());
      heldCount--;
    end
  endtask

  task automatic waitDrained();
    while (outCount != acceptedTotal || returnTimes.size() != 0 || heldCount != 0) begin
      @(posedge CLK);
      #2;
    end
    fairWindow = 1'b0;
  endtask

  // Receiver returns at most one credit per cycle
  always @(posedge CLK) begin : returnCredits
    int idx;
    #2;
    idx = -1;
    foreach (returnTimes[i]) begin
      if (idx < 0 && returnTimes[i] <= cycleCount) begin
        idx = i;
      end
    end
    if (idx >= 0) begin
      returnTimes.delete(idx);
      downCredit = 1'b1;
    end else begin
      downCredit = 1'b0;
    end
  end

  always @(negedge CLK) begin : watchOutputs
    int lane;
    int nextLane;
    if (RESETN) begin
      for (int l = 0; l < bufferCfgPkg::NUM_LANES; l++) begin
        if (upCredit[l]) begin
          upCredits[l]++;
          upPulses[l]++;
        end
      end
      if (outValid) begin
        lane = int'(outWord.lane);
        if (outCount + 1 - returnedCount > bufferCfgPkg::OUT_CREDITS) begin
          stopOnError("drain sent a word without a downstream credit");
        end
        if (expQ[lane].size() == 0) begin
          stopOnError($sformatf("unexpected word 0x%0h on lane %0d", outWord.data, lane));
        end else begin
          checkValue($sformatf("outWord.data lane %0d", lane), outWord.data,
                     expQ[lane].pop_front());
        end
        // Next lane after the last served wins while it is backlogged
        if (fairWindow && prevLane >= 0) begin
          nextLane = (prevLane + 1) % bufferCfgPkg::NUM_LANES;
          if (inFlight[nextLane] > 0) begin
            checkValue("outWord.lane", lane, nextLane);
            fairChecks++;
          end
        end
        inFlight[lane]--;
        prevLane = lane;
        outCount++;
        if (creditsHeld) begin
          heldCount++;
        end else begin
          returnTimes.push_back(cycleCount + 1 + randomDelay());
        end
      end
      if (downCredit) begin
        returnedCount++;
      end
    end
  end

  initial begin : watchdog
    wait (lineCount > 0);
    repeat (40 * lineCount + 200) @(posedge CLK);
    stopOnError("watchdog expired before the golden sequence finished");
  end

  initial begin : mainFlow
    RESETN = 1'b0;
    inValid = 1'b0;
    inWord = '0;
    for (int l = 0; l < bufferCfgPkg::NUM_LANES; l++) begin
      upCredits[l] = bufferCfgPkg::FIFO_DEPTH;
    end
    loadGolden();
    if (lineCount == 0) begin
      stopOnError("golden file holds no commands");
    end
    repeat (4) @(posedge CLK);
    #2;
    RESETN = 1'b1;

    // Quiet outputs before any traffic
    repeat (3) begin
      @(negedge CLK);
      checkValue("outValid", outValid, 1'b0);
      checkValue("upCredit", upCredit, '0);
      checkValue("creditError", creditError, 1'b0);
    end
    @(posedge CLK);
    #2;

    for (int i = 0; i < cmdList.size(); i++) begin
      case (cmdList[i])
        "I": sendWord(laneList[i], dataList[i], 1'b0);
        "X": sendWord(laneList[i], dataList[i], 1'b1);
        "P": creditsHeld = 1'b1;
        "R": releaseCredits();
        "D": waitDrained();
        default: stopOnError($sformatf("unknown golden command %c", cmdList[i]));
      endcase
    end
    waitDrained();
    repeat (4) begin
      @(posedge CLK);
      #2;
    end

    for (int l = 0; l < bufferCfgPkg::NUM_LANES; l++) begin
      checkValue($sformatf("expected words left lane %0d", l), expQ[l].size(), 0);
      checkValue($sformatf("upCredit pulses lane %0d", l), upPulses[l], accepted[l]);
      checkValue($sformatf("upstream credits lane %0d", l), upCredits[l],
                 bufferCfgPkg::FIFO_DEPTH);
    end
    checkValue("creditError", creditError, sawNoCreditWord);
    if (fairChecks < 2 * bufferCfgPkg::NUM_LANES) begin
      stopOnError("round-robin order was checked on too few backlogged outputs");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/laneBuffer_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module laneBufferAssert (
  input wire                         CLK,
  input wire                         RESETN,
  input bufferTypesPkg::laneMaskT    lanePop,
  input bufferTypesPkg::laneMaskT    laneNotEmpty,
  input bufferTypesPkg::laneMaskT    laneWrite,
  input bufferTypesPkg::laneMaskT    laneFull,
  input wire                         outValid,
  input wire                         downCredit
);

  // Words presented downstream and not yet credited back
  int outstanding;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(outValid) - int'(downCredit);
    end
  end

  // Drain serves one lane per cycle at most
  popOneHot: assert property (@(posedge CLK) disable iff (!RESETN)
    $onehot0(lanePop))
    else $error("lanePop has more than one bit set: %b", lanePop);

  popNotEmpty: assert property (@(posedge CLK) disable iff (!RESETN)
    (lanePop & ~laneNotEmpty) == '0)
    else $error("pop from an empty lane: pop %b notEmpty %b", lanePop, laneNotEmpty);

  // Dispatcher credit mirror keeps writes off full FIFOs
  writeNotFull: assert property (@(posedge CLK) disable iff (!RESETN)
    (laneWrite & laneFull) == '0)
    else $error("write to a full lane: write %b full %b", laneWrite, laneFull);

  // Each output word needs a credit the receiver has not used up
  outHadCredit: assert property (@(posedge CLK) disable iff (!RESETN)
    outValid |-> outstanding < bufferCfgPkg::OUT_CREDITS)
    else $error("outValid without a downstream credit");

endmodule

bind laneBuffer laneBufferAssert u_laneBufferAssert (
  .CLK          (CLK),
  .RESETN       (RESETN),
  .lanePop      (lanePop),
  .laneNotEmpty (laneNotEmpty),
  .laneWrite    (laneWrite),
  .laneFull     (laneFull),
  .outValid     (outValid),
  .downCredit   (downCredit)
);

`default_nettype wire

/* dv/laneBuffer_golden.txt */
# I lane data sends a word, E lane data expects it out, X lane data sends without credit
# P holds downstream credits, R releases them, D waits until every word is out
P
I 0 1000
I 1 1100
I 2 1200
I 3 1300
E 0 1000
E 1 1100
E 2 1200
E 3 1300
# Fill lane 2 until upstream has no credit left for it
I 2 2201
I 2 2202
I 2 2203
I 2 2204
I 2 2205
I 2 2206
I 2 2207
I 2 2208
E 2 2201
E 2 2202
E 2 2203
E 2 2204
E 2 2205
E 2 2206
E 2 2207
E 2 2208
X 2 dead
# Backlog on the other lanes while downstream credits are held
I 0 3001
I 1 3101
I 3 3301
I 0 3002
I 1 3102
I 3 3302
E 0 3001
E 0 3002
E 1 3101
E 1 3102
E 3 3301
E 3 3302
R
D

/* run.sh */
#!/usr/bin/env bash
# Build the lane buffer testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir \
  && verilator --binary --timing --assert -Wno-fatal \
       -f compile.f --top-module laneBufferTb -o laneBufferSim \
  && ./obj_dir/laneBufferSim \
  || { echo "simulation did not complete cleanly"; exit 1; }

/* verilog/bufferCfgPkg.sv */
`default_nettype none

package bufferCfgPkg;

  // Lane geometry
  localparam int NUM_LANES = 4;
  localparam int LANE_BITS = 2;

  // Entries per lane FIFO
  localparam int FIFO_DEPTH = 8;

  // Read and write pointers carry one extra wrap bit
  localparam int PTR_BITS = 4;

  // Payload width of one word
  localparam int DATA_BITS = 16;

  // Credits the receiver grants the drain at reset
  localparam int OUT_CREDITS = 4;

  // Wide enough for FIFO_DEPTH and OUT_CREDITS
  localparam int CREDIT_BITS = 4;

endpackage

`default_nettype wire

/* verilog/bufferTypesPkg.sv */
`default_nettype none

package bufferTypesPkg;

  // Index of one lane
  typedef logic [bufferCfgPkg::LANE_BITS-1:0] laneIdT;

  // Word payload
  typedef logic [bufferCfgPkg::DATA_BITS-1:0] dataT;

  // Credit counters, upstream mirrors and downstream count
  typedef logic [bufferCfgPkg::CREDIT_BITS-1:0] creditCountT;

  // One bit per lane
  typedef logic [bufferCfgPkg::NUM_LANES-1:0] laneMaskT;

  // Word with its lane tag, used at both sides of the buffer
  typedef struct packed {
    laneIdT lane;
    dataT   data;
  } laneWordT;

endpackage

`default_nettype wire

/* verilog/laneBuffer.sv */
`timescale 1ns/10ps
`default_nettype none

module laneBuffer (
  input  wire                       CLK,
  input  wire                       RESETN,
  input  bufferTypesPkg::laneWordT  inWord,
  input  wire                       inValid,
  output bufferTypesPkg::laneMaskT  upCredit,
  output logic                      creditError,
  output bufferTypesPkg::laneWordT  outWord,
  output logic                      outValid,
  input  wire                       downCredit
);

  bufferTypesPkg::laneMaskT laneWrite;
  bufferTypesPkg::dataT     writeData;
  bufferTypesPkg::laneMaskT lanePop;
  bufferTypesPkg::laneMaskT laneNotEmpty;
  // Only watched by the bound checks
  bufferTypesPkg::laneMaskT laneFull;
  bufferTypesPkg::dataT [bufferCfgPkg::NUM_LANES-1:0] laneHead;

  laneDispatcher u_dispatcher (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .inWord      (inWord),
    .inValid     (inValid),
    .lanePop     (lanePop),
    .laneWrite   (laneWrite),
    .writeData   (writeData),
    .upCredit    (upCredit),
    .creditError (creditError)
  );

  for (genvar g = 0; g < bufferCfgPkg::NUM_LANES; g++) begin : gLane
    laneFifo u_fifo (
      .CLK       (CLK),
      .RESETN    (RESETN),
      .write     (laneWrite[g]),
      .writeData (writeData),
      .pop       (lanePop[g]),
      .headData  (laneHead[g]),
      .notEmpty  (laneNotEmpty[g]),
      .full      (laneFull[g])
    );
  end

  roundRobinDrain u_drain (
    .CLK          (CLK),
    .RESETN       (RESETN),
    .laneHead     (laneHead),
    .laneNotEmpty (laneNotEmpty),
    .downCredit   (downCredit),
    .lanePop      (lanePop),
    .outWord      (outWord),
    .outValid     (outValid)
  );

endmodule

`default_nettype wire

/* verilog/laneDispatcher.sv */
`timescale 1ns/10ps
`default_nettype none

module laneDispatcher (
  input  wire                       CLK,
  input  wire                       RESETN,
  input  bufferTypesPkg::laneWordT  inWord,
  input  wire                       inValid,
  input  bufferTypesPkg::laneMaskT  lanePop,
  output bufferTypesPkg::laneMaskT  laneWrite,
  output bufferTypesPkg::dataT      writeData,
  output bufferTypesPkg::laneMaskT  upCredit,
  output logic                      creditError
);

  // Copy of the credits upstream still holds per lane
  bufferTypesPkg::creditCountT upMirror [bufferCfgPkg::NUM_LANES];

  logic noCredit;
  logic accept;

  assign noCredit = (upMirror[inWord.lane] == '0);
  assign accept   = inValid & ~noCredit;

  // One-hot write strobe, empty for dropped words
  always_comb begin
    laneWrite = '0;
    laneWrite[inWord.lane] = accept;
  end

  assign writeData = inWord.data;

  // Write and pop in the same cycle cancel out
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      for (int l = 0; l < bufferCfgPkg::NUM_LANES; l++) begin
        upMirror[l] <= bufferTypesPkg::creditCountT'(bufferCfgPkg::FIFO_DEPTH);
      end
    end else begin
      for (int l = 0; l < bufferCfgPkg::NUM_LANES; l++) begin
        upMirror[l] <= upMirror[l]
                       - bufferTypesPkg::creditCountT'(laneWrite[l])
                       + bufferTypesPkg::creditCountT'(lanePop[l]);
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      creditError <= 1'b0;
    end else if (inValid && noCredit) begin
      creditError <= 1'b1;
    end
  end

  // Credit return lines up with outValid of the popped word
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      upCredit <= '0;
    end else begin
      upCredit <= lanePop;
    end
  end

endmodule

`default_nettype wire

/* verilog/laneFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module laneFifo (
  input  wire                  CLK,
  input  wire                  RESETN,
  input  wire                  write,
  input  bufferTypesPkg::dataT writeData,
  input  wire                  pop,
  output bufferTypesPkg::dataT headData,
  output logic                 notEmpty,
  output logic                 full
);

  bufferTypesPkg::dataT mem [bufferCfgPkg::FIFO_DEPTH];

  // Pointers with wrap bit in the MSB
  logic [bufferCfgPkg::PTR_BITS-1:0] wrPtr;
  logic [bufferCfgPkg::PTR_BITS-1:0] rdPtr;
  logic [bufferCfgPkg::PTR_BITS-1:0] wrPtrNext;
  logic [bufferCfgPkg::PTR_BITS-1:0] rdPtrNext;

  // Slot addresses without the wrap bit
  logic [bufferCfgPkg::PTR_BITS-2:0] wrAddr;
  logic [bufferCfgPkg::PTR_BITS-2:0] rdAddrNext;

  logic wrInc;
  logic rdInc;
  logic fullNext;
  logic notEmptyNext;

  // Overflow and underflow requests are dropped here
  assign wrInc = write & ~full;
  assign rdInc = pop & notEmpty;

  assign wrPtrNext = wrInc ? wrPtr + 1'b1 : wrPtr;
  assign rdPtrNext = rdInc ? rdPtr + 1'b1 : rdPtr;

  assign wrAddr     = wrPtr[bufferCfgPkg::PTR_BITS-2:0];
  assign rdAddrNext = rdPtrNext[bufferCfgPkg::PTR_BITS-2:0];

  // Same slot, opposite wrap bits
  assign fullNext =
    (wrPtrNext[bufferCfgPkg::PTR_BITS-1] != rdPtrNext[bufferCfgPkg::PTR_BITS-1]) &&
    (wrPtrNext[bufferCfgPkg::PTR_BITS-2:0] == rdAddrNext);
  assign notEmptyNext = (wrPtrNext != rdPtrNext);

  always_ff @(posedge CLK) begin
    if (wrInc) begin
      mem[wrAddr] <= writeData;
    end
  end

  // Lookahead head register
  // a write into the next head slot goes straight to headData
  always_ff @(posedge CLK) begin
    if (wrInc && (wrAddr == rdAddrNext)) begin
      headData <= writeData;
    end else begin
      headData <= mem[rdAddrNext];
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      wrPtr <= wrPtrNext;
      rdPtr <= rdPtrNext;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      full     <= 1'b0;
      notEmpty <= 1'b0;
    end else begin
      full     <= fullNext;
      notEmpty <= notEmptyNext;
    end
  end

endmodule

`default_nettype wire

/* verilog/roundRobinDrain.sv */
`timescale 1ns/10ps
`default_nettype none

module roundRobinDrain (
  input  wire                       CLK,
  input  wire                       RESETN,
  input  bufferTypesPkg::dataT [bufferCfgPkg::NUM_LANES-1:0] laneHead,
  input  bufferTypesPkg::laneMaskT  laneNotEmpty,
  input  wire                       downCredit,
  output bufferTypesPkg::laneMaskT  lanePop,
  output bufferTypesPkg::laneWordT  outWord,
  output logic                      outValid
);

  // First lane to look at, one past the last lane served
  bufferTypesPkg::laneIdT rrPtr;

  bufferTypesPkg::laneIdT searchLane;
  bufferTypesPkg::laneIdT pick;
  logic found;
  logic popValid;

  bufferTypesPkg::creditCountT creditCount;

  // Scan all lanes starting at rrPtr, first hit wins
  always_comb begin
    found = 1'b0;
    pick = rrPtr;
    searchLane = rrPtr;
    for (int i = 0; i < bufferCfgPkg::NUM_LANES; i++) begin
      searchLane = rrPtr + bufferTypesPkg::laneIdT'(i);
      if (!found && laneNotEmpty[searchLane]) begin
        found = 1'b1;
        pick = searchLane;
      end
    end
  end

  assign popValid = found && (creditCount != '0);

  always_comb begin
    lanePop = '0;
    lanePop[pick] = popValid;
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      rrPtr <= '0;
    end else if (popValid) begin
      rrPtr <= pick + 1'b1;
    end
  end

  // Pop spends a credit, downCredit returns one, both may coincide
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      creditCount <= bufferTypesPkg::creditCountT'(bufferCfgPkg::OUT_CREDITS);
    end else begin
      creditCount <= creditCount
                     - bufferTypesPkg::creditCountT'(popValid)
                     + bufferTypesPkg::creditCountT'(downCredit);
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= popValid;
    end
  end

  // Output payload, only meaningful with outValid
  always_ff @(posedge CLK) begin
    if (popValid) begin
      outWord.lane <= pick;
      outWord.data <= laneHead[pick];
    end
  end

endmodule

`default_nettype wire
